//--- Bender.yml
package:
  name: spi_link

sources:
  # Packages first, both are imported by the RTL
  - files:
      - common/spi_pkg.sv
      - common/link_pkg.sv
  # RTL
  - files:
      - spi/spi_pin_sync.sv
      - spi/spi_slave_port.sv
      - source/link_checker.sv
      - source/spi_link_top.sv
  # Testbench
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_spi_link.sv

//--- common/link_pkg.sv
`default_nettype none

package link_pkg;

	// ########################################
	// Link checker counters
	// ########################################

	localparam int BYTE_COUNT_W  = 8;  // Running byte index, wraps at 256
	localparam int MATCH_COUNT_W = 8;  // Matching bytes, wraps at 256

	// Bytes received since reset, never cleared by ssel
	typedef logic [BYTE_COUNT_W-1:0] byte_count_t;

	// Bytes whose value equalled their own index
	typedef logic [MATCH_COUNT_W-1:0] match_count_t;

	// link_ok is high only while the match count sits exactly here
	localparam match_count_t LINK_MATCH_TARGET = match_count_t'(64);

	// One more match pushes the count past the target
	// and link_ok drops again

endpackage

`default_nettype wire

//--- common/spi_pkg.sv
`default_nettype none

package spi_pkg;

	// ########################################
	// Framing on the wire
	// ########################################

	localparam int SPI_BYTE_W    = 8;  // Bits per byte on mosi and miso
	localparam int SPI_BIT_IDX_W = 3;  // Wide enough to count eight bits

	// One data byte as it travels over the wire
	// Sent and received MSB first in mode 0
	typedef logic [SPI_BYTE_W-1:0] spi_byte_t;

	// Position of the current bit within a byte
	typedef logic [SPI_BIT_IDX_W-1:0] bit_idx_t;

	// Index of the eighth and final bit
	localparam bit_idx_t SPI_LAST_BIT = bit_idx_t'(SPI_BYTE_W - 1);

	// ########################################
	// Notes
	// ########################################

	// sck idles low, ssel is active low
	// Data sampled on rising sck, shifted on falling sck
	// Bit index wraps from SPI_LAST_BIT back to zero

endpackage

`default_nettype wire

//--- source/link_checker.sv
`timescale 1ns/1ps
`default_nettype none

module link_checker
	import spi_pkg::*, link_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        byte_strobe,  // One pulse per received byte
	input  spi_byte_t   rx_byte,      // Valid with byte_strobe
	output byte_count_t byte_count,   // Running index that doubles as the reply
	output logic        link_ok       // High while the match count is on target
);

	match_count_t match_count;  // Bytes that equalled their index
	logic         match_hit;    // Current byte equals the old index

	// ########################################
	// Pattern compare
	// ########################################

	// Expected pattern is 0, 1, 2 ... so the byte is its own index
	assign match_hit = (byte_count_t'(rx_byte) == byte_count);

	// ########################################
	// Counters
	// ########################################

	// Byte index
	// Survives ssel and only reset clears it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			byte_count <= '0;
		end else if (byte_strobe) begin
			byte_count <= byte_count + byte_count_t'(1);  // Wraps at 256
		end
	end

	// Match counter compared against the index before it advances
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			match_count <= '0;
		end else if (byte_strobe && match_hit) begin
			match_count <= match_count + match_count_t'(1);
		end
	end

	// ########################################
	// Link flag
	// ########################################

	// Exact compare so more matches than the target drop the flag
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			link_ok <= 1'b0;
		end else begin
			link_ok <= (match_count == LINK_MATCH_TARGET);  // One cycle behind
		end
	end

	// Every strobe brings a fully defined byte into the compare
	rx_byte_known: assert property (
		@(posedge clk) disable iff (!arst_n)
		byte_strobe |-> !$isunknown(rx_byte)
	);

endmodule

`default_nettype wire

//--- source/spi_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_link_top
	import spi_pkg::*, link_pkg::*;
(
	input  logic clk,
	input  logic arst_n,
	input  logic sck,      // Driven by the external master
	input  logic ssel,     // Active low
	input  logic mosi,
	output logic miso,     // Running byte count sent MSB first
	output logic link_ok   // Exactly LINK_MATCH_TARGET bytes matched
);

	// Synchronizer to port
	logic sck_rise;
	logic sck_fall;
	logic ssel_active;
	logic ssel_start;
	logic mosi_bit;

	// Port and checker
	logic        byte_strobe;
	spi_byte_t   rx_byte;
	byte_count_t byte_count;  // Fed back as the reply

	// ########################################
	// Pin synchronizer
	// ########################################

	spi_pin_sync u_spi_pin_sync (
		.clk         (clk),
		.arst_n      (arst_n),
		.sck         (sck),
		.ssel        (ssel),
		.mosi        (mosi),
		.sck_rise    (sck_rise),
		.sck_fall    (sck_fall),
		.ssel_active (ssel_active),
		.ssel_start  (ssel_start),
		.mosi_bit    (mosi_bit)
	);

	// Shift registers and framing
	spi_slave_port u_spi_slave_port (
		.clk         (clk),
		.arst_n      (arst_n),
		.sck_rise    (sck_rise),
		.sck_fall    (sck_fall),
		.ssel_active (ssel_active),
		.ssel_start  (ssel_start),
		.mosi_bit    (mosi_bit),
		.byte_count  (byte_count),
		.byte_strobe (byte_strobe),
		.rx_byte     (rx_byte),
		.reply_load  (),            // Reloads the reply inside the port
		.miso        (miso)
	);

	link_checker u_link_checker (
		.clk         (clk),
		.arst_n      (arst_n),
		.byte_strobe (byte_strobe),
		.rx_byte     (rx_byte),
		.byte_count  (byte_count),
		.link_ok     (link_ok)
	);

endmodule

`default_nettype wire

//--- spi/spi_pin_sync.sv
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sync (
	input  logic clk,
	input  logic arst_n,
	input  logic sck,          // Raw pin async to clk
	input  logic ssel,         // Active low raw pin
	input  logic mosi,         // Raw pin
	output logic sck_rise,     // One clk pulse per rising sck
	output logic sck_fall,     // One clk pulse per falling sck
	output logic ssel_active,  // High while ssel is held low
	output logic ssel_start,   // One clk pulse when ssel falls
	output logic mosi_bit      // Synchronized data aligned to sck_rise
);

	logic [2:0] sck_hist;   // Bit 0 holds the newest sample
	logic [2:0] ssel_hist;
	logic [1:0] mosi_hist;

	// ########################################
	// Sampling registers
	// ########################################

	// sck history with a low idle level
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sck_hist <= 3'b000;
		end else begin
			sck_hist <= {sck_hist[1:0], sck};
		end
	end

	// ssel history starts deselected so reset gives no start pulse
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ssel_hist <= 3'b111;
		end else begin
			ssel_hist <= {ssel_hist[1:0], ssel};
		end
	end

	// Two flops are enough for a level
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mosi_hist <= 2'b00;
		end else begin
			mosi_hist <= {mosi_hist[0], mosi};
		end
	end

	// ########################################
	// Edge decode from the two oldest flops
	// ########################################

	assign sck_rise    = (sck_hist[2:1] == 2'b01);   // Low then high
	assign sck_fall    = (sck_hist[2:1] == 2'b10);   // High then low
	assign ssel_active = ~ssel_hist[1];              // Active low pin
	assign ssel_start  = (ssel_hist[2:1] == 2'b10);  // Frame opens on falling ssel

	// Same depth as sck_hist[1] so the bit is stable with sck_rise
	assign mosi_bit = mosi_hist[1];

	// Each sck level lasts at least 4 clk which keeps the edges apart
	sck_edges_apart: assert property (
		@(posedge clk) disable iff (!arst_n)
		(sck_rise || sck_fall) |=> !(sck_rise || sck_fall) [*3]
	);

endmodule

`default_nettype wire

//--- spi/spi_slave_port.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave_port
	import spi_pkg::*, link_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  logic        sck_rise,     // From the pin synchronizer
	input  logic        sck_fall,
	input  logic        ssel_active,
	input  logic        ssel_start,
	input  logic        mosi_bit,
	input  byte_count_t byte_count,   // Count to send back as the reply
	output logic        byte_strobe,  // One pulse per complete byte
	output spi_byte_t   rx_byte,      // Valid with byte_strobe
	output logic        reply_load,   // One cycle after byte_strobe
	output logic        miso
);

	bit_idx_t  bit_idx;       // Next bit position within the byte
	spi_byte_t rx_shift;      // MSB first receive shift register
	spi_byte_t reply_shift;   // Transmit shift register with its MSB on miso
	logic      ssel_start_d;  // Delayed start that loads the first reply
	logic      last_bit;      // Current rise carries the eighth bit
	logic      reply_reload;  // Either load condition

	// ########################################
	// Receive side
	// ########################################

	assign last_bit = ssel_active && sck_rise && (bit_idx == SPI_LAST_BIT);

	// Bit counter
	// Held at zero outside a frame so an aborted byte is dropped
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_idx <= '0;
		end else if (!ssel_active) begin
			bit_idx <= '0;               // Frame ended or never started
		end else if (sck_rise) begin
			bit_idx <= bit_idx + 1'b1;   // Wraps to zero after the eighth bit
		end
	end

	// Receive shift register, new bits enter at the LSB
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rx_shift <= '0;
		end else if (ssel_active && sck_rise) begin
			rx_shift <= {rx_shift[SPI_BYTE_W-2:0], mosi_bit};
		end
	end

	assign rx_byte = rx_shift;  // Complete in the strobe cycle

	// Byte strobe and the follow-up reply load
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			byte_strobe <= 1'b0;
			reply_load  <= 1'b0;
		end else begin
			byte_strobe <= last_bit;     // Lands with the eighth bit in rx_shift
			reply_load  <= byte_strobe;  // Checker count has moved by now
		end
	end

	// ########################################
	// Reply side
	// ########################################

	// Same spacing behind ssel_start as reply_load behind byte_strobe
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ssel_start_d <= 1'b0;
		end else begin
			ssel_start_d <= ssel_start;
		end
	end

	assign reply_reload = ssel_start_d || reply_load;

	// Reply shift register
	// No shift on the falling sck that opens a byte
	// The new reply MSB waits on miso for the next rising sck
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reply_shift <= '0;
		end else if (reply_reload) begin
			reply_shift <= spi_byte_t'(byte_count);  // Load wins over a shift
		end else if (ssel_active && sck_fall && (bit_idx != '0)) begin
			reply_shift <= {reply_shift[SPI_BYTE_W-2:0], 1'b0};  // Zeros fill in
		end
	end

	assign miso = reply_shift[SPI_BYTE_W-1];  // MSB first

	// ########################################
	// Checks
	// ########################################

	// Every frame opens with the bit counter at zero
	bit_idx_clear_at_start: assert property (
		@(posedge clk) disable iff (!arst_n)
		ssel_start |-> (bit_idx == '0)
	);

	// A strobe always falls inside the frame that carried its byte
	byte_strobe_in_frame: assert property (
		@(posedge clk) disable iff (!arst_n)
		byte_strobe |-> ssel_active
	);

endmodule

`default_nettype wire

//--- tb.f
+incdir+test
common/spi_pkg.sv
common/link_pkg.sv
spi/spi_pin_sync.sv
spi/spi_slave_port.sv
source/link_checker.sv
source/spi_link_top.sv
test/tb_spi_link.sv

//--- test/tb_spi_tasks.svh
`ifndef TB_SPI_TASKS_SVH
`define TB_SPI_TASKS_SVH

// ########################################
// Checking helpers
// ########################################

// Compares one observed value with the model
task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
	check_count++;
	assert (got === exp) else begin
		$display("Mismatch at time %0t: %s is 0x%02h, expected 0x%02h", $time, what, got, exp);
		error_count++;
	end
endtask

// Counters inside the checker and the link flag against the model
task automatic check_counters();
	@(negedge clk);  // Away from the update edge
	check_value("byte count", u_spi_link_top.u_link_checker.byte_count, exp_count);
	check_value("match count", u_spi_link_top.u_link_checker.match_count, exp_match);
	check_value("link_ok", {7'b0, link_ok}, {7'b0, (exp_match == LINK_MATCH_TARGET)});
endtask

task automatic report_test(input string name, input int errors_before);
	$display("Test %s: %s, %0d errors", name,
		(error_count == errors_before) ? "ok" : "failed", error_count - errors_before);
endtask

// ########################################
// Mode 0 master
// ########################################

// Clocks n_bits from tx_buf, MSB first, and collects miso into rx_buf
// n_bits below 8 * n_bytes leaves the frame mid-byte
task automatic spi_xfer(input int n_bytes, input int n_bits);
	int k;
	int byte_i;
	int bit_i;
	for (k = 0; k < n_bytes; k++) begin
		rx_buf[k] = '0;
	end
	@(posedge clk);
	ssel <= 1'b0;
	repeat (SCK_HALF) @(posedge clk);  // Reply loads about 4 clk after ssel falls
	for (k = 0; k < n_bits; k++) begin
		byte_i = k / 8;
		bit_i  = 7 - (k % 8);
		sck  <= 1'b0;                  // Shift edge
		mosi <= tx_buf[byte_i][bit_i];
		repeat (SCK_HALF - 1) @(posedge clk);
		@(negedge clk);
		rx_buf[byte_i][bit_i] = miso;  // Just ahead of the rising sck
		@(posedge clk);
		sck <= 1'b1;                   // Sample edge
		repeat (SCK_HALF) @(posedge clk);
	end
	sck <= 1'b0;
	repeat (SCK_HALF) @(posedge clk);
	ssel <= 1'b1;
	mosi <= 1'b0;
	repeat (SCK_HALF + 3) @(posedge clk);  // Let ssel settle through the synchronizer
endtask

// Full frame with model update and reply checks
task automatic run_frame(input int n_bytes);
	int i;
	for (i = 0; i < n_bytes; i++) begin
		exp_reply[i] = spi_byte_t'(exp_count);  // Reply is the count before this byte
		if (byte_count_t'(tx_buf[i]) == exp_count) begin
			exp_match = exp_match + match_count_t'(1);
		end
		exp_count = exp_count + byte_count_t'(1);
	end
	spi_xfer(n_bytes, 8 * n_bytes);
	for (i = 0; i < n_bytes; i++) begin
		check_value($sformatf("reply byte %0d", i), rx_buf[i], exp_reply[i]);
	end
	check_counters();
endtask

// ########################################
// Directed tests
// ########################################

// Idle outputs, then pattern byte 0
task automatic test_reset_state();
	int errs;
	errs = error_count;
	@(negedge clk);
	check_value("link_ok after reset", {7'b0, link_ok}, 8'h00);
	check_value("miso after reset", {7'b0, miso}, 8'h00);
	tx_buf[0] = 8'h00;
	run_frame(1);
	check_value("first reply", rx_buf[0], 8'h00);
	report_test("reset_state", errs);
endtask

// Bytes 1 to 63 in seven frames of nine
task automatic test_match_pattern();
	int errs;
	int f;
	int i;
	errs = error_count;
	for (f = 0; f < 7; f++) begin
		for (i = 0; i < 9; i++) begin
			tx_buf[i] = spi_byte_t'(1 + f * 9 + i);
		end
		run_frame(9);
	end
	check_value("link_ok at target", {7'b0, link_ok}, 8'h01);
	report_test("match_pattern", errs);
endtask

// A 65th match passes the target
task automatic test_overshoot();
	int errs;
	errs = error_count;
	tx_buf[0] = 8'd64;
	run_frame(1);
	check_value("link_ok past target", {7'b0, link_ok}, 8'h00);
	report_test("overshoot", errs);
endtask

// Non-matching random bytes, two frames of eight
task automatic test_random_bytes();
	int          errs;
	int          f;
	int          i;
	logic [31:0] r;
	spi_byte_t   idx;
	errs = error_count;
	for (f = 0; f < 2; f++) begin
		idx = spi_byte_t'(exp_count);
		for (i = 0; i < 8; i++) begin
			r = $random(seed);
			tx_buf[i] = (r[7:0] == idx) ? ~r[7:0] : r[7:0];  // Never its own index
			idx = idx + 8'd1;
		end
		run_frame(8);
	end
	report_test("random_bytes", errs);
endtask

// Four bits then ssel high, the byte must vanish
task automatic test_aborted_frame();
	int errs;
	errs = error_count;
	tx_buf[0] = spi_byte_t'(exp_count);  // Would match if completed
	spi_xfer(1, 4);
	check_value("aborted reply high nibble", {4'h0, rx_buf[0][7:4]}, {4'h0, exp_count[7:4]});
	check_counters();
	tx_buf[0] = spi_byte_t'(exp_count);
	run_frame(1);  // Reply must still be the unchanged count
	report_test("aborted_frame", errs);
endtask

`endif

//--- test/tb_spi_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_link
	import spi_pkg::*, link_pkg::*;
();

	// ########################################
	// Run constants
	// ########################################

	localparam int CLK_PERIOD   = 10;  // ns
	localparam int SCK_HALF     = 5;   // clk cycles per sck level
	localparam int RESET_CYCLES = 8;
	localparam int MAX_FRAME    = 16;  // Largest frame any test sends
	localparam int TOTAL_BYTES  = 84;  // A little above the bytes all tests clock
	localparam int MARGIN_NS    = 20000;  // Frame lead, tail and settle time
	localparam int WATCHDOG_NS  = TOTAL_BYTES * 16 * SCK_HALF * CLK_PERIOD + MARGIN_NS;

	logic clk;
	logic arst_n;
	logic sck;
	logic ssel;      // Active low
	logic mosi;
	logic miso;
	logic link_ok;

	// Frame buffers shared with the master task
	spi_byte_t tx_buf    [MAX_FRAME];
	spi_byte_t rx_buf    [MAX_FRAME];
	spi_byte_t exp_reply [MAX_FRAME];

	// Reference model of the checker
	byte_count_t  exp_count;  // Bytes received so far
	match_count_t exp_match;  // Bytes equal to their index

	integer seed;
	int     check_count;
	int     error_count;

	`include "tb_spi_tasks.svh"

	// ########################################
	// Clock, DUT, watchdog
	// ########################################

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	spi_link_top u_spi_link_top (
		.clk     (clk),
		.arst_n  (arst_n),
		.sck     (sck),
		.ssel    (ssel),
		.mosi    (mosi),
		.miso    (miso),
		.link_ok (link_ok)
	);

	// Ends a stuck run
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("SIMULATION FAILED");
		$finish;
	end

	// ########################################
	// Test sequence
	// ########################################

	initial begin
		arst_n      = 1'b0;
		sck         = 1'b0;  // Mode 0 idle level
		ssel        = 1'b1;  // Deselected
		mosi        = 1'b0;
		seed        = 32'h78c0a1ef;
		check_count = 0;
		error_count = 0;
		exp_count   = '0;
		exp_match   = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		repeat (4) @(posedge clk);

		test_reset_state();
		test_match_pattern();
		test_overshoot();
		test_random_bytes();
		test_aborted_frame();

		$display("Checks: %0d run, %0d failed", check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
